// ==== design/hist_consts.svh ====
`ifndef HIST_CONSTS_SVH
`define HIST_CONSTS_SVH

// input sample width
`define HIST_SAMPLE_W 8

// previous samples held for comparison
`define HIST_WIN_DEPTH 9

// bins: ci weighs 100, ni weighs 10, rd weighs 1
`define HIST_NUM_BINS 200

// per-bin counter width, wraps on overflow
`define HIST_CNT_W 16

// window range is scaled down by this many bits
`define HIST_RANGE_SHIFT 4

// clamp for rd and top value of ni
`define HIST_FEAT_MAX 9

`endif

// ==== design/hist_pkg.sv ====
`include "hist_consts.svh"

package hist_pkg;

    // one input sample
    typedef logic [`HIST_SAMPLE_W-1:0] sample_t;

    // ni or rd value, 0..9
    typedef logic [$clog2(`HIST_FEAT_MAX + 1)-1:0] feat_t;

    // histogram address, 0..199
    typedef logic [$clog2(`HIST_NUM_BINS)-1:0] bin_idx_t;

    // one bin count
    typedef logic [`HIST_CNT_W-1:0] bin_cnt_t;

endpackage

// ==== design/hist_sample_window.sv ====
`include "hist_consts.svh"

module hist_sample_window import hist_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sample_valid_i,
    input  sample_t sample_i,
    output sample_t win_o [`HIST_WIN_DEPTH],
    output sample_t cur_o,
    output logic    win_valid_o
);

    localparam int FILL_W = $clog2(`HIST_WIN_DEPTH + 1);

    logic [FILL_W-1:0] fill_q;
    logic              win_full;
    logic              win_valid_q;
    sample_t           cur_q;
    sample_t           win_q [`HIST_WIN_DEPTH];

    // all nine slots hold real samples
    assign win_full = (fill_q == FILL_W'(`HIST_WIN_DEPTH));

    // control: fill level and output strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_q      <= '0;
            win_valid_q <= 1'b0;
        end else begin
            win_valid_q <= sample_valid_i && win_full;
            if (sample_valid_i && !win_full) begin
                fill_q <= fill_q + 1'b1;
            end
        end
    end

    // data: new sample becomes current, old current enters slot 0
    always_ff @(posedge clk) begin
        if (sample_valid_i) begin
            cur_q    <= sample_i;
            win_q[0] <= cur_q;
            for (int i = 1; i < `HIST_WIN_DEPTH; i++) begin
                win_q[i] <= win_q[i-1];
            end
        end
    end

    assign cur_o       = cur_q;
    assign win_o       = win_q;
    assign win_valid_o = win_valid_q;

endmodule

// ==== design/hist_feature_extract.sv ====
`include "hist_consts.svh"

module hist_feature_extract import hist_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t win_i [`HIST_WIN_DEPTH],
    input  sample_t cur_i,
    input  logic    win_valid_i,
    output logic    ci_o,
    output feat_t   ni_o,
    output feat_t   rd_o,
    output logic    feat_valid_o
);

    logic    ci_d;
    feat_t   ni_d;
    feat_t   rd_d;
    sample_t win_min;
    sample_t win_max;
    sample_t win_range;
    sample_t range_scaled;

    logic    ci_q;
    feat_t   ni_q;
    feat_t   rd_q;
    logic    feat_valid_q;

    // slot 0 is the sample just before the current one
    assign ci_d = (cur_i > win_i[0]);

    // neighbors strictly below the current sample
    always_comb begin
        ni_d = '0;
        for (int i = 0; i < `HIST_WIN_DEPTH; i++) begin
            if (win_i[i] < cur_i) begin
                ni_d = ni_d + 1'b1;
            end
        end
    end

    // window extremes
    always_comb begin
        win_min = win_i[0];
        win_max = win_i[0];
        for (int i = 1; i < `HIST_WIN_DEPTH; i++) begin
            if (win_i[i] < win_min) begin
                win_min = win_i[i];
            end
            if (win_i[i] > win_max) begin
                win_max = win_i[i];
            end
        end
    end

    assign win_range    = win_max - win_min;
    assign range_scaled = win_range >> `HIST_RANGE_SHIFT;

    // ranges of 160 and up all land in class 9
    assign rd_d = (range_scaled > sample_t'(`HIST_FEAT_MAX)) ?
                  feat_t'(`HIST_FEAT_MAX) : feat_t'(range_scaled);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            feat_valid_q <= 1'b0;
        end else begin
            feat_valid_q <= win_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            ci_q <= ci_d;
            ni_q <= ni_d;
            rd_q <= rd_d;
        end
    end

    assign ci_o         = ci_q;
    assign ni_o         = ni_q;
    assign rd_o         = rd_q;
    assign feat_valid_o = feat_valid_q;

endmodule

// ==== design/hist_bin_index.sv ====
`include "hist_consts.svh"

module hist_bin_index import hist_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ci_i,
    input  feat_t    ni_i,
    input  feat_t    rd_i,
    input  logic     feat_valid_i,
    output bin_idx_t bin_idx_o,
    output logic     bin_valid_o
);

    bin_idx_t ci_scaled;
    bin_idx_t ni_scaled;
    bin_idx_t rd_ext;
    bin_idx_t idx_d;
    bin_idx_t idx_q;
    logic     bin_valid_q;

    // ci * 100 = ci * (64 + 32 + 4)
    assign ci_scaled = (bin_idx_t'(ci_i) << 6) + (bin_idx_t'(ci_i) << 5) +
                       (bin_idx_t'(ci_i) << 2);

    // ni * 10 = ni * (8 + 2)
    assign ni_scaled = (bin_idx_t'(ni_i) << 3) + (bin_idx_t'(ni_i) << 1);

    assign rd_ext = bin_idx_t'(rd_i);
    // tops out at 100 + 90 + 9, below the bin count
    assign idx_d  = ci_scaled + ni_scaled + rd_ext;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bin_valid_q <= 1'b0;
        end else begin
            bin_valid_q <= feat_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (feat_valid_i) begin
            idx_q <= idx_d;
        end
    end

    assign bin_idx_o   = idx_q;
    assign bin_valid_o = bin_valid_q;

endmodule

// ==== design/hist_bin_memory.sv ====
`include "hist_consts.svh"

module hist_bin_memory import hist_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  bin_idx_t bin_idx_i,
    input  logic     bin_valid_i,
    input  logic     count_en_i,
    input  logic     read_en_i,
    output bin_cnt_t bin_count_o,
    output logic     done_read_o
);

    localparam bin_idx_t LAST_BIN = bin_idx_t'(`HIST_NUM_BINS - 1);

    bin_cnt_t cnt_q [`HIST_NUM_BINS];
    bin_idx_t rd_idx_q;
    bin_idx_t rd_idx_next;
    bin_cnt_t count_q;
    logic     done_q;
    logic     inc_en;
    logic     last_bin;

    // samples that arrive with counting off are dropped here
    assign inc_en = bin_valid_i && count_en_i;

    assign last_bin    = (rd_idx_q == LAST_BIN);
    assign rd_idx_next = last_bin ? '0 : rd_idx_q + 1'b1;

    // increment wins over readout and the read index holds for that cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `HIST_NUM_BINS; i++) begin
                cnt_q[i] <= '0;
            end
            rd_idx_q <= '0;
            count_q  <= '0;
            done_q   <= 1'b0;
        end else if (inc_en) begin
            // wraps at full scale
            cnt_q[bin_idx_i] <= cnt_q[bin_idx_i] + 1'b1;
            if (!read_en_i) begin
                count_q <= '0;
                done_q  <= 1'b0;
            end
        end else if (read_en_i) begin
            count_q  <= cnt_q[rd_idx_q];
            done_q   <= last_bin;
            rd_idx_q <= rd_idx_next;
        end else begin
            count_q <= '0;
            done_q  <= 1'b0;
        end
    end

    assign bin_count_o = count_q;
    assign done_read_o = done_q;

endmodule

// ==== design/hist_top.sv ====
`include "hist_consts.svh"

module hist_top import hist_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     sample_valid_i,
    input  sample_t  sample_i,
    input  logic     count_en_i,
    input  logic     read_en_i,
    output bin_cnt_t bin_count_o,
    output logic     done_read_o
);

    // window stage to feature stage
    sample_t  win [`HIST_WIN_DEPTH];
    sample_t  cur;
    logic     win_valid;

    // feature stage to index stage
    logic     ci;
    feat_t    ni;
    feat_t    rd;
    logic     feat_valid;

    // index stage to memory
    bin_idx_t bin_idx;
    logic     bin_valid;

    hist_sample_window u_window (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .win_o          (win),
        .cur_o          (cur),
        .win_valid_o    (win_valid)
    );

    hist_feature_extract u_feature (
        .clk          (clk),
        .rst_n        (rst_n),
        .win_i        (win),
        .cur_i        (cur),
        .win_valid_i  (win_valid),
        .ci_o         (ci),
        .ni_o         (ni),
        .rd_o         (rd),
        .feat_valid_o (feat_valid)
    );

    hist_bin_index u_index (
        .clk          (clk),
        .rst_n        (rst_n),
        .ci_i         (ci),
        .ni_i         (ni),
        .rd_i         (rd),
        .feat_valid_i (feat_valid),
        .bin_idx_o    (bin_idx),
        .bin_valid_o  (bin_valid)
    );

    hist_bin_memory u_memory (
        .clk         (clk),
        .rst_n       (rst_n),
        .bin_idx_i   (bin_idx),
        .bin_valid_i (bin_valid),
        .count_en_i  (count_en_i),
        .read_en_i   (read_en_i),
        .bin_count_o (bin_count_o),
        .done_read_o (done_read_o)
    );

endmodule

// ==== test/hist_tb_pkg.sv ====
`include "hist_consts.svh"

package hist_tb_pkg;

    localparam int DIR_ROWS = 16;
    localparam int NO_FEAT  = -1;

    // directed rows, nine fill samples then one feature per row
    // after fill: flat, ni 9 with ci set, rd 1, rd clamp, range 255, ni 8, ci clear
    logic [7:0] dir_sample [DIR_ROWS] = '{
        8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40,
        8'h40, 8'h50, 8'hff, 8'h00, 8'h00, 8'h80, 8'h80
    };
    int dir_bin [DIR_ROWS] = '{
        NO_FEAT, NO_FEAT, NO_FEAT, NO_FEAT, NO_FEAT, NO_FEAT, NO_FEAT, NO_FEAT, NO_FEAT,
        0, 190, 191, 9, 9, 189, 79
    };

    // reference model state, slot 0 is the newest previous sample
    logic [7:0]  win_model [`HIST_WIN_DEPTH];
    int          fill_model;
    int          hist_model [`HIST_NUM_BINS];
    int unsigned lcg_state;

    function automatic void model_reset();
        fill_model = 0;
        lcg_state  = 36014;
        for (int i = 0; i < `HIST_NUM_BINS; i++) begin
            hist_model[i] = 0;
        end
    endfunction

    function automatic logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // bin of a new sample against the model window
    function automatic int feature_bin(logic [7:0] s);
        int ci;
        int ni;
        int lo;
        int hi;
        int rd;
        ci = (s > win_model[0]) ? 1 : 0;
        ni = 0;
        lo = 255;
        hi = 0;
        for (int i = 0; i < `HIST_WIN_DEPTH; i++) begin
            ni = (win_model[i] < s) ? ni + 1 : ni;
            lo = (win_model[i] < lo) ? win_model[i] : lo;
            hi = (win_model[i] > hi) ? win_model[i] : hi;
        end
        rd = (hi - lo) >> `HIST_RANGE_SHIFT;
        rd = (rd > `HIST_FEAT_MAX) ? `HIST_FEAT_MAX : rd;
        return ci * 100 + ni * 10 + rd;
    endfunction

    // returns the sample's bin, or NO_FEAT while the window fills
    function automatic int model_apply(logic [7:0] s, bit counting);
        int idx;
        idx = NO_FEAT;
        if (fill_model == `HIST_WIN_DEPTH) begin
            idx = feature_bin(s);
            if (counting) begin
                hist_model[idx]++;
            end
        end else begin
            fill_model++;
        end
        for (int i = `HIST_WIN_DEPTH - 1; i > 0; i--) begin
            win_model[i] = win_model[i-1];
        end
        win_model[0] = s;
        return idx;
    endfunction

endpackage

// ==== test/hist_tb.sv ====
`include "hist_consts.svh"

module hist_tb import hist_pkg::*, hist_tb_pkg::*; ();

    // sample strobe to counter update, fixed by the pipeline
    localparam int PIPE_DEPTH   = 3;
    localparam int READ_TIMEOUT = 400;
    localparam int RAND_COUNT   = 300;
    localparam int IDLE_COUNT   = 40;
    localparam int TAIL_COUNT   = 30;

    logic     clk;
    logic     rst_n;
    logic     sample_valid;
    sample_t  sample_data;
    logic     count_en;
    logic     read_en;
    bin_cnt_t bin_count;
    logic     done_read;
    int       expected_hist [`HIST_NUM_BINS];

    hist_top u_hist_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_valid_i (sample_valid),
        .sample_i       (sample_data),
        .count_en_i     (count_en),
        .read_en_i      (read_en),
        .bin_count_o    (bin_count),
        .done_read_o    (done_read)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic send_sample(input sample_t s, output int model_idx);
        sample_valid = 1'b1;
        sample_data  = s;
        model_idx    = model_apply(s, count_en);
        @(negedge clk);
    endtask

    task automatic finish_burst();
        sample_valid = 1'b0;
        repeat (PIPE_DEPTH + 1) @(negedge clk);
    endtask

    task automatic apply_directed(input int first, input int last);
        int model_idx;
        for (int r = first; r <= last; r++) begin
            send_sample(dir_sample[r], model_idx);
            check_value("model bin of table row", model_idx, dir_bin[r]);
            if (dir_bin[r] != NO_FEAT) begin
                expected_hist[dir_bin[r]]++;
            end
        end
        finish_burst();
    endtask

    task automatic apply_random(input int count);
        int model_idx;
        for (int n = 0; n < count; n++) begin
            send_sample(lcg_next(), model_idx);
        end
        finish_burst();
    endtask

    task automatic expect_model_hist();
        for (int i = 0; i < `HIST_NUM_BINS; i++) begin
            expected_hist[i] = hist_model[i];
        end
    endtask

    // full readout, read_en stays high afterwards when hold_read is set
    task automatic read_histogram(input bit hold_read);
        int idx;
        int cycles;
        bit done;
        idx     = 0;
        cycles  = 0;
        done    = 1'b0;
        read_en = 1'b1;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > READ_TIMEOUT) begin
                $display("Readout did not finish within %0d cycles", READ_TIMEOUT);
                fail_run();
            end
            check_value("bin_count_o", bin_count, expected_hist[idx] & 'hffff);
            check_value("done_read_o", done_read, idx == `HIST_NUM_BINS - 1);
            done = done_read;
            idx++;
        end
        if (!hold_read) begin
            read_en = 1'b0;
            @(negedge clk);
            check_value("bin_count_o", bin_count, 0);
            check_value("done_read_o", done_read, 0);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample_data  = '0;
        count_en     = 1'b0;
        read_en      = 1'b0;
        model_reset();
        for (int i = 0; i < `HIST_NUM_BINS; i++) begin
            expected_hist[i] = 0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // all bins empty straight after reset
        read_histogram(1'b0);

        // nine fill samples give no feature
        count_en = 1'b1;
        apply_directed(0, `HIST_WIN_DEPTH - 1);
        read_histogram(1'b0);
        apply_directed(`HIST_WIN_DEPTH, DIR_ROWS - 1);
        read_histogram(1'b0);

        // strobe high every cycle, three samples in flight
        apply_random(RAND_COUNT);
        expect_model_hist();
        read_histogram(1'b0);

        // counting off still shifts the window, seen by the samples after it
        count_en = 1'b0;
        apply_random(IDLE_COUNT);
        count_en = 1'b1;
        apply_random(TAIL_COUNT);
        expect_model_hist();

        // second readout wraps to bin 0 with no gap
        read_histogram(1'b1);
        read_histogram(1'b0);

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== joint_hist.f ====
+incdir+design
design/hist_pkg.sv
design/hist_sample_window.sv
design/hist_feature_extract.sv
design/hist_bin_index.sv
design/hist_bin_memory.sv
design/hist_top.sv
test/hist_tb_pkg.sv
test/hist_tb.sv

// ==== Bender.yml ====
package:
  name: joint_hist

export_include_dirs:
  - design

sources:
  - design/hist_pkg.sv
  - design/hist_sample_window.sv
  - design/hist_feature_extract.sv
  - design/hist_bin_index.sv
  - design/hist_bin_memory.sv
  - design/hist_top.sv
  - target: test
    files:
      - test/hist_tb_pkg.sv
      - test/hist_tb.sv
